// File: tb/tb_clk_gen.sv
/*
  Testbench clock and reset
  - 40 ns clock period
  - Reset held high for the first 4 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic c0_ddr4_clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 4;

  initial begin
    c0_ddr4_clk_o = 1'b0;
    forever #HALF_PERIOD c0_ddr4_clk_o = ~c0_ddr4_clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge c0_ddr4_clk_o);
    @(negedge c0_ddr4_clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/tb_ddr_app_checker.sv
/*
  Testbench checker
  - Model of the store, calibration, open rows and status counters
  - Queue of expected reads with their due cycles
  - Compares DUT outputs and counts errors
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_app_checker (
  input  wire         c0_ddr4_clk,
  input  wire         reset_i,
  input  wire         req_valid_i,
  input  wire  [1:0]  req_cmd_i,
  input  wire  [7:0]  req_addr_i,
  input  wire  [63:0] req_data_i,
  input  wire  [7:0]  req_mask_i,
  input  wire         calib_i,
  input  wire         rd_valid_i,
  input  wire  [63:0] rd_data_i,
  input  wire         compare_error_i,
  input  wire  [15:0] mismatch_count_i,
  input  wire  [15:0] wr_count_i,
  input  wire  [15:0] rd_count_i,
  input  wire  [15:0] row_miss_count_i,
  input  wire         check_i,
  output int          pending_o,
  output int          error_count_o,
  output int          check_count_o
);

  logic [63:0] store [256];
  logic [2:0]  open_row [4];
  logic [3:0]  open_flag;
  logic        err;
  int          clear_cnt;
  int          cycle;
  int          wr_cnt;
  int          rd_cnt;
  int          miss_cnt;
  int          mis_cnt;
  int          due_q [$];
  logic [63:0] data_q [$];
  logic        err_q [$];

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count_o++;
    if (got !== exp) begin
      $display("FAIL %s: got %0h, expected %0h", name, got, exp);
      error_count_o++;
    end
  endtask

  task automatic drop_front();
    void'(due_q.pop_front());
    void'(data_q.pop_front());
    void'(err_q.pop_front());
  endtask

  // ****************************************
  // Model update for an accepted request
  // ****************************************
  task automatic apply_request();
    logic [7:0] idx;
    logic [1:0] bank;
    logic [2:0] row;
    bank = req_addr_i[1:0];
    row  = req_addr_i[7:5];
    // Word index is bank, row, column
    idx  = {bank, row, req_addr_i[4:2]};
    if (!open_flag[bank] || open_row[bank] != row) miss_cnt++;
    open_flag[bank] = 1'b1;
    open_row[bank]  = row;
    if (req_cmd_i == ddr_app_pkg::CMD_WRITE) begin
      wr_cnt++;
      for (int b = 0; b < 8; b++) begin
        if (!req_mask_i[b]) store[idx][b*8 +: 8] = req_data_i[b*8 +: 8];
      end
    end else begin
      rd_cnt++;
      if (req_cmd_i == ddr_app_pkg::CMD_READ_CMP && store[idx] != req_data_i) begin
        mis_cnt++;
        err = 1'b1;
      end
      due_q.push_back(cycle + 3);
      data_q.push_back(store[idx]);
      err_q.push_back(err);
    end
  endtask

  always @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      clear_cnt = 0;
      open_flag = '0;
      err       = 1'b0;
      wr_cnt    = 0;
      rd_cnt    = 0;
      miss_cnt  = 0;
      mis_cnt   = 0;
      due_q.delete();
      data_q.delete();
      err_q.delete();
      foreach (store[i]) store[i] = '0;
    end else begin
      // Store clear takes one cycle per word
      compare("init_calib_complete_o", calib_i, clear_cnt >= 256);
      if (rd_valid_i === 1'b1) begin
        if (due_q.size() == 0) begin
          $display("rd_valid_o came at cycle %0d with no read outstanding", cycle);
          error_count_o++;
        end else begin
          if (due_q[0] != cycle) begin
            $display("Read due at cycle %0d returned at cycle %0d", due_q[0], cycle);
            error_count_o++;
          end
          compare("rd_data_o", rd_data_i, data_q[0]);
          compare("compare_error_o", compare_error_i, err_q[0]);
          drop_front();
        end
      end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
        $display("No rd_valid_o for the read due at cycle %0d", due_q[0]);
        error_count_o++;
        drop_front();
      end
      if (req_valid_i && clear_cnt >= 256 && req_cmd_i != 2'd0) apply_request();
      if (clear_cnt < 256) clear_cnt++;
      if (check_i) begin
        compare("wr_count_o", wr_count_i, 16'(wr_cnt));
        compare("rd_count_o", rd_count_i, 16'(rd_cnt));
        compare("row_miss_count_o", row_miss_count_i, 16'(miss_cnt));
        compare("mismatch_count_o", mismatch_count_i, 16'(mis_cnt));
        compare("compare_error_o", compare_error_i, err);
      end
    end
    cycle++;
    pending_o = due_q.size();
  end

endmodule

`default_nettype wire

// File: tb/tb_ddr_app_top.sv
/*
  Testbench top for the DDR4 user-clock subsystem
  - LFSR stimulus driven on the falling clock edge
  - Calibration, masked write, back-to-back, compare and row tests
  - Cycle limit and closing summary
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_app_top;

  localparam int NUM_REQUESTS   = 282;
  localparam int TIMEOUT_CYCLES = 400 + 5 * NUM_REQUESTS + 200;

  wire         c0_ddr4_clk;
  wire         reset;
  logic        req_valid;
  logic [1:0]  req_cmd;
  logic [7:0]  req_addr;
  logic [63:0] req_data;
  logic [7:0]  req_mask;
  logic        check_counters;
  wire         calib;
  wire         rd_valid;
  wire  [63:0] rd_data;
  wire         compare_error;
  wire  [15:0] mismatch_count;
  wire  [15:0] wr_count;
  wire  [15:0] rd_count;
  wire  [15:0] row_miss_count;
  int          pending;
  int          checker_errors;
  int          checks;
  int          top_errors;
  int          base_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  int          waited;
  logic [31:0] lfsr = 32'hc812;
  logic [63:0] rnd;
  logic [7:0]  addr;
  logic [7:0]  addr_list [64];
  logic [63:0] cmp_data [8];

  tb_clk_gen u_clk_gen (.c0_ddr4_clk_o(c0_ddr4_clk), .reset_o(reset));

  ddr_app_top dut0 (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset),
    .req_valid_i           (req_valid),
    .req_cmd_i             (req_cmd),
    .req_addr_i            (req_addr),
    .req_data_i            (req_data),
    .req_mask_i            (req_mask),
    .init_calib_complete_o (calib),
    .rd_valid_o            (rd_valid),
    .rd_data_o             (rd_data),
    .compare_error_o       (compare_error),
    .mismatch_count_o      (mismatch_count),
    .wr_count_o            (wr_count),
    .rd_count_o            (rd_count),
    .row_miss_count_o      (row_miss_count)
  );

  tb_ddr_app_checker u_checker (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .reset_i          (reset),
    .req_valid_i      (req_valid),
    .req_cmd_i        (req_cmd),
    .req_addr_i       (req_addr),
    .req_data_i       (req_data),
    .req_mask_i       (req_mask),
    .calib_i          (calib),
    .rd_valid_i       (rd_valid),
    .rd_data_i        (rd_data),
    .compare_error_i  (compare_error),
    .mismatch_count_i (mismatch_count),
    .wr_count_i       (wr_count),
    .rd_count_i       (rd_count),
    .row_miss_count_i (row_miss_count),
    .check_i          (check_counters),
    .pending_o        (pending),
    .error_count_o    (checker_errors),
    .check_count_o    (checks)
  );

  // ****************************************
  // Stimulus helpers
  // ****************************************
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic send(input logic [1:0] cmd, input logic [7:0] a, input logic [63:0] d,
                      input logic [7:0] m);
    @(negedge c0_ddr4_clk);
    req_valid = 1'b1;
    req_cmd   = cmd;
    req_addr  = a;
    req_data  = d;
    req_mask  = m;
  endtask

  task automatic send_random(input logic [1:0] cmd, output logic [7:0] a);
    logic [63:0] ra;
    logic [63:0] rd;
    logic [63:0] rm;
    take_bits(8, ra);
    take_bits(64, rd);
    take_bits(8, rm);
    a = ra[7:0];
    send(cmd, ra[7:0], rd, rm[7:0]);
  endtask

  task automatic go_idle();
    @(negedge c0_ddr4_clk);
    req_valid = 1'b0;
    req_cmd   = 2'd0;
  endtask

  // Drain the pipeline, then have the checker compare the counters
  task automatic finish_test(input string name);
    int errs;
    go_idle();
    while (pending != 0) @(negedge c0_ddr4_clk);
    repeat (3) @(negedge c0_ddr4_clk);
    check_counters = 1'b1;
    @(negedge c0_ddr4_clk);
    check_counters = 1'b0;
    errs = checker_errors + top_errors - base_errors;
    base_errors = checker_errors + top_errors;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (errs == 0) ? "passed" : "failed", errs);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************
  initial begin
    req_valid      = 1'b0;
    req_cmd        = 2'd0;
    req_addr       = '0;
    req_data       = '0;
    req_mask       = '0;
    check_counters = 1'b0;
    wait (reset == 1'b0);

    // Requests during the clear must be dropped
    for (int i = 0; i < 4; i++) send_random(i[0] ? ddr_app_pkg::CMD_READ : 2'd1, addr);
    go_idle();
    waited = 0;
    while (calib !== 1'b1 && waited < ddr_app_pkg::STORE_DEPTH + 8) begin
      @(negedge c0_ddr4_clk);
      waited++;
    end
    if (calib !== 1'b1) begin
      $display("init_calib_complete_o did not rise after the store clear");
      top_errors++;
    end
    send_random(ddr_app_pkg::CMD_READ, addr);
    finish_test("calibration");

    for (int i = 0; i < 64; i++) send_random(ddr_app_pkg::CMD_WRITE, addr_list[i]);
    for (int i = 0; i < 64; i++) send(ddr_app_pkg::CMD_READ, addr_list[i], '0, '0);
    finish_test("masked writes");

    // Half the reads hit the address written one cycle earlier
    for (int i = 0; i < 32; i++) begin
      send_random(ddr_app_pkg::CMD_WRITE, addr);
      take_bits(9, rnd);
      send(ddr_app_pkg::CMD_READ, rnd[0] ? addr : rnd[8:1], '0, '0);
    end
    finish_test("back-to-back");

    // Distinct addresses so each expected word stays valid
    for (int i = 0; i < 8; i++) begin
      take_bits(5, rnd);
      addr_list[i] = {rnd[4:0], 3'(i)};
      take_bits(64, cmp_data[i]);
      send(ddr_app_pkg::CMD_WRITE, addr_list[i], cmp_data[i], 8'h00);
    end
    for (int i = 0; i < 8; i++) send(ddr_app_pkg::CMD_READ_CMP, addr_list[i], cmp_data[i], '0);
    send(ddr_app_pkg::CMD_READ_CMP, addr_list[5], cmp_data[5] ^ 64'h1, '0);
    for (int i = 0; i < 4; i++) send(ddr_app_pkg::CMD_READ_CMP, addr_list[i], cmp_data[i], '0);
    finish_test("read-compare");

    // Any command code, no-ops included
    for (int i = 0; i < 64; i++) begin
      take_bits(2, rnd);
      send_random(rnd[1:0], addr);
    end
    finish_test("row tracking");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, checker_errors + top_errors);
    if (checker_errors + top_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  always @(posedge c0_ddr4_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ddr_app_decode.sv
/*
  Request decode stage
  - Drops requests before calibration and no-op commands
  - Splits the application address into bank, row and column
  - Tracks the open row of each bank and flags row misses
*/
`timescale 1ns/1ps
`default_nettype none

module ddr_app_decode (
  input  wire                                    c0_ddr4_clk,
  input  wire                                    reset_i,
  input  wire                                    req_valid_i,
  input  wire  [ddr_app_pkg::CMD_WIDTH-1:0]      req_cmd_i,
  input  wire  [ddr_app_pkg::APP_ADDR_WIDTH-1:0] req_addr_i,
  input  wire  [ddr_app_pkg::DATA_WIDTH-1:0]     req_data_i,
  input  wire  [ddr_app_pkg::MASK_WIDTH-1:0]     req_mask_i,
  input  wire                                    calib_done_i,
  output logic                                   dec_valid_o,
  output logic [ddr_app_pkg::CMD_WIDTH-1:0]      dec_cmd_o,
  output logic [ddr_app_pkg::BANK_WIDTH-1:0]     dec_bank_o,
  output logic [ddr_app_pkg::ROW_WIDTH-1:0]      dec_row_o,
  output logic [ddr_app_pkg::COL_WIDTH-1:0]      dec_col_o,
  output logic [ddr_app_pkg::DATA_WIDTH-1:0]     dec_data_o,
  output logic [ddr_app_pkg::MASK_WIDTH-1:0]     dec_mask_o,
  output logic                                   row_miss_o
);

  logic                                accept;
  logic                                miss;
  logic [ddr_app_pkg::BANK_WIDTH-1:0]  req_bank;
  logic [ddr_app_pkg::ROW_WIDTH-1:0]   req_row;
  logic [ddr_app_pkg::COL_WIDTH-1:0]   req_col;

  // Open row per bank, valid only where the matching flag is set
  logic [ddr_app_pkg::ROW_WIDTH-1:0]   open_row [ddr_app_pkg::NUM_BANKS];
  logic [ddr_app_pkg::NUM_BANKS-1:0]   open_flag;

  // ****************************************
  // Address split and acceptance
  // ****************************************
  assign req_bank = req_addr_i[ddr_app_pkg::BANK_LSB +: ddr_app_pkg::BANK_WIDTH];
  assign req_col  = req_addr_i[ddr_app_pkg::COL_LSB +: ddr_app_pkg::COL_WIDTH];
  assign req_row  = req_addr_i[ddr_app_pkg::ROW_LSB +: ddr_app_pkg::ROW_WIDTH];

  assign accept = req_valid_i & calib_done_i & (req_cmd_i != ddr_app_pkg::CMD_NOP);

  // Closed bank or a different row both count as a miss
  assign miss = ~open_flag[req_bank] | (open_row[req_bank] != req_row);

  // Strobes and open flags
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
      row_miss_o  <= 1'b0;
      open_flag   <= '0;
    end else begin
      dec_valid_o <= accept;
      row_miss_o  <= accept & miss;
      if (accept) begin
        open_flag[req_bank] <= 1'b1;
      end
    end
  end

  // ****************************************
  // Payload registers
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (accept) begin
      dec_cmd_o          <= req_cmd_i;
      dec_bank_o         <= req_bank;
      dec_row_o          <= req_row;
      dec_col_o          <= req_col;
      dec_data_o         <= req_data_i;
      dec_mask_o         <= req_mask_i;
      open_row[req_bank] <= req_row;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ddr_app_execute.sv
/*
  Execute stage with the on-chip backing store
  - Clears every store word after reset, then signals calibration done
  - Masked byte writes and registered word reads
  - Carries the request data forward as the expected value
*/
`timescale 1ns/1ps
`default_nettype none

module ddr_app_execute (
  input  wire                                 c0_ddr4_clk,
  input  wire                                 reset_i,
  input  wire                                 dec_valid_i,
  input  wire  [ddr_app_pkg::CMD_WIDTH-1:0]   dec_cmd_i,
  input  wire  [ddr_app_pkg::BANK_WIDTH-1:0]  dec_bank_i,
  input  wire  [ddr_app_pkg::ROW_WIDTH-1:0]   dec_row_i,
  input  wire  [ddr_app_pkg::COL_WIDTH-1:0]   dec_col_i,
  input  wire  [ddr_app_pkg::DATA_WIDTH-1:0]  dec_data_i,
  input  wire  [ddr_app_pkg::MASK_WIDTH-1:0]  dec_mask_i,
  output logic                                calib_done_o,
  output logic                                ex_valid_o,
  output logic [ddr_app_pkg::CMD_WIDTH-1:0]   ex_cmd_o,
  output logic [ddr_app_pkg::DATA_WIDTH-1:0]  ex_rdata_o,
  output logic [ddr_app_pkg::DATA_WIDTH-1:0]  ex_expect_o
);

  localparam logic [ddr_app_pkg::STORE_INDEX_WIDTH-1:0] LAST_INDEX =
    ddr_app_pkg::STORE_INDEX_WIDTH'(ddr_app_pkg::STORE_DEPTH - 1);

  logic [ddr_app_pkg::DATA_WIDTH-1:0]        store [ddr_app_pkg::STORE_DEPTH];
  logic [ddr_app_pkg::STORE_INDEX_WIDTH-1:0] clear_idx;
  logic [ddr_app_pkg::STORE_INDEX_WIDTH-1:0] access_idx;
  logic [ddr_app_pkg::STORE_INDEX_WIDTH-1:0] wr_idx;
  logic [ddr_app_pkg::MASK_WIDTH-1:0]        wr_be;
  logic [ddr_app_pkg::DATA_WIDTH-1:0]        wr_word;
  logic                                      wr_en;

  // ****************************************
  // Post-reset clear sequence
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      clear_idx    <= '0;
      calib_done_o <= 1'b0;
    end else if (!calib_done_o) begin
      clear_idx <= clear_idx + 1'b1;
      if (clear_idx == LAST_INDEX) begin
        calib_done_o <= 1'b1;
      end
    end
  end

  // ****************************************
  // Store write port
  // ****************************************
  assign access_idx = {dec_bank_i, dec_row_i, dec_col_i};

  // The clear owns the write port until calibration completes
  assign wr_en   = ~calib_done_o | (dec_valid_i & (dec_cmd_i == ddr_app_pkg::CMD_WRITE));
  assign wr_idx  = calib_done_o ? access_idx : clear_idx;
  assign wr_be   = calib_done_o ? ~dec_mask_i : '1;
  assign wr_word = calib_done_o ? dec_data_i : '0;

  always_ff @(posedge c0_ddr4_clk) begin
    if (wr_en) begin
      for (int b = 0; b < ddr_app_pkg::MASK_WIDTH; b++) begin
        if (wr_be[b]) begin
          store[wr_idx][b*ddr_app_pkg::BYTE_WIDTH +: ddr_app_pkg::BYTE_WIDTH] <=
            wr_word[b*ddr_app_pkg::BYTE_WIDTH +: ddr_app_pkg::BYTE_WIDTH];
        end
      end
    end
  end

  // ****************************************
  // Result handoff
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i;
    end
  end

  // Read data for a write command is never used downstream
  always_ff @(posedge c0_ddr4_clk) begin
    if (dec_valid_i) begin
      ex_cmd_o    <= dec_cmd_i;
      ex_rdata_o  <= store[access_idx];
      ex_expect_o <= dec_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ddr_app_pkg.sv
/*
  Shared definitions for the DDR4 user-clock subsystem
  - Request widths for address, data and byte mask
  - Address field positions in ROW_COLUMN_BANK order
  - Backing store size and command codes
  - Status counter width
*/
`default_nettype none

package ddr_app_pkg;

  // ****************************************
  // Request widths
  // ****************************************
  localparam int APP_ADDR_WIDTH = 8;
  localparam int DATA_WIDTH     = 64;
  // A mask bit of 1 keeps that byte unchanged
  localparam int MASK_WIDTH     = 8;
  localparam int BYTE_WIDTH     = DATA_WIDTH / MASK_WIDTH;

  // ****************************************
  // Address fields, row high and bank low
  // ****************************************
  localparam int BANK_LSB   = 0;
  localparam int BANK_WIDTH = 2;
  localparam int COL_LSB    = 2;
  localparam int COL_WIDTH  = 3;
  localparam int ROW_LSB    = 5;
  localparam int ROW_WIDTH  = 3;
  localparam int NUM_BANKS  = 4;

  // Store word index is bank, then row, then column
  localparam int STORE_DEPTH       = 256;
  localparam int STORE_INDEX_WIDTH = BANK_WIDTH + ROW_WIDTH + COL_WIDTH;

  // ****************************************
  // Commands and status
  // ****************************************
  localparam int CMD_WIDTH = 2;
  localparam logic [CMD_WIDTH-1:0] CMD_NOP      = 2'd0;
  localparam logic [CMD_WIDTH-1:0] CMD_WRITE    = 2'd1;
  localparam logic [CMD_WIDTH-1:0] CMD_READ     = 2'd2;
  localparam logic [CMD_WIDTH-1:0] CMD_READ_CMP = 2'd3;

  localparam int COUNT_WIDTH = 16;

endpackage

`default_nettype wire

// File: verilog/ddr_app_result.sv
/*
  Result stage
  - Returns read data for plain and compare reads
  - Sticky compare error and mismatch count
  - Write, read and row miss counters
*/
`timescale 1ns/1ps
`default_nettype none

module ddr_app_result (
  input  wire                                 c0_ddr4_clk,
  input  wire                                 reset_i,
  input  wire                                 ex_valid_i,
  input  wire  [ddr_app_pkg::CMD_WIDTH-1:0]   ex_cmd_i,
  input  wire  [ddr_app_pkg::DATA_WIDTH-1:0]  ex_rdata_i,
  input  wire  [ddr_app_pkg::DATA_WIDTH-1:0]  ex_expect_i,
  input  wire                                 row_miss_i,
  output logic                                rd_valid_o,
  output logic [ddr_app_pkg::DATA_WIDTH-1:0]  rd_data_o,
  output logic                                compare_error_o,
  output logic [ddr_app_pkg::COUNT_WIDTH-1:0] mismatch_count_o,
  output logic [ddr_app_pkg::COUNT_WIDTH-1:0] wr_count_o,
  output logic [ddr_app_pkg::COUNT_WIDTH-1:0] rd_count_o,
  output logic [ddr_app_pkg::COUNT_WIDTH-1:0] row_miss_count_o
);

  logic is_write;
  logic is_read;
  logic mismatch;

  assign is_write = ex_valid_i & (ex_cmd_i == ddr_app_pkg::CMD_WRITE);
  assign is_read  = ex_valid_i & ((ex_cmd_i == ddr_app_pkg::CMD_READ) |
                                  (ex_cmd_i == ddr_app_pkg::CMD_READ_CMP));
  assign mismatch = ex_valid_i & (ex_cmd_i == ddr_app_pkg::CMD_READ_CMP) &
                    (ex_rdata_i != ex_expect_i);

  // ****************************************
  // Status and counters
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      rd_valid_o       <= 1'b0;
      compare_error_o  <= 1'b0;
      mismatch_count_o <= '0;
      wr_count_o       <= '0;
      rd_count_o       <= '0;
      row_miss_count_o <= '0;
    end else begin
      rd_valid_o <= is_read;
      if (mismatch) begin
        compare_error_o  <= 1'b1;
        mismatch_count_o <= mismatch_count_o + 1'b1;
      end
      if (is_write) begin
        wr_count_o <= wr_count_o + 1'b1;
      end
      if (is_read) begin
        rd_count_o <= rd_count_o + 1'b1;
      end
      // Miss strobe runs one stage ahead, the count is the same
      if (row_miss_i) begin
        row_miss_count_o <= row_miss_count_o + 1'b1;
      end
    end
  end

  // Returned word
  always_ff @(posedge c0_ddr4_clk) begin
    if (is_read) begin
      rd_data_o <= ex_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ddr_app_top.sv
/*
  Top level of the DDR4 user-clock subsystem
  - Decode, execute and result stages in a three-cycle pipeline
  - Calibration flag from the store clear
*/
`timescale 1ns/1ps
`default_nettype none

module ddr_app_top (
  input  wire                                    c0_ddr4_clk,
  input  wire                                    reset_i,
  input  wire                                    req_valid_i,
  input  wire  [ddr_app_pkg::CMD_WIDTH-1:0]      req_cmd_i,
  input  wire  [ddr_app_pkg::APP_ADDR_WIDTH-1:0] req_addr_i,
  input  wire  [ddr_app_pkg::DATA_WIDTH-1:0]     req_data_i,
  input  wire  [ddr_app_pkg::MASK_WIDTH-1:0]     req_mask_i,
  output wire                                    init_calib_complete_o,
  output wire                                    rd_valid_o,
  output wire  [ddr_app_pkg::DATA_WIDTH-1:0]     rd_data_o,
  output wire                                    compare_error_o,
  output wire  [ddr_app_pkg::COUNT_WIDTH-1:0]    mismatch_count_o,
  output wire  [ddr_app_pkg::COUNT_WIDTH-1:0]    wr_count_o,
  output wire  [ddr_app_pkg::COUNT_WIDTH-1:0]    rd_count_o,
  output wire  [ddr_app_pkg::COUNT_WIDTH-1:0]    row_miss_count_o
);

  wire                                 calib_done;
  wire                                 dec_valid;
  wire [ddr_app_pkg::CMD_WIDTH-1:0]    dec_cmd;
  wire [ddr_app_pkg::BANK_WIDTH-1:0]   dec_bank;
  wire [ddr_app_pkg::ROW_WIDTH-1:0]    dec_row;
  wire [ddr_app_pkg::COL_WIDTH-1:0]    dec_col;
  wire [ddr_app_pkg::DATA_WIDTH-1:0]   dec_data;
  wire [ddr_app_pkg::MASK_WIDTH-1:0]   dec_mask;
  wire                                 row_miss;
  wire                                 ex_valid;
  wire [ddr_app_pkg::CMD_WIDTH-1:0]    ex_cmd;
  wire [ddr_app_pkg::DATA_WIDTH-1:0]   ex_rdata;
  wire [ddr_app_pkg::DATA_WIDTH-1:0]   ex_expect;

  assign init_calib_complete_o = calib_done;

  // ****************************************
  // Pipeline stages
  // ****************************************
  ddr_app_decode u_decode (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_cmd_i    (req_cmd_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .req_mask_i   (req_mask_i),
    .calib_done_i (calib_done),
    .dec_valid_o  (dec_valid),
    .dec_cmd_o    (dec_cmd),
    .dec_bank_o   (dec_bank),
    .dec_row_o    (dec_row),
    .dec_col_o    (dec_col),
    .dec_data_o   (dec_data),
    .dec_mask_o   (dec_mask),
    .row_miss_o   (row_miss)
  );

  ddr_app_execute u_execute (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .reset_i      (reset_i),
    .dec_valid_i  (dec_valid),
    .dec_cmd_i    (dec_cmd),
    .dec_bank_i   (dec_bank),
    .dec_row_i    (dec_row),
    .dec_col_i    (dec_col),
    .dec_data_i   (dec_data),
    .dec_mask_i   (dec_mask),
    .calib_done_o (calib_done),
    .ex_valid_o   (ex_valid),
    .ex_cmd_o     (ex_cmd),
    .ex_rdata_o   (ex_rdata),
    .ex_expect_o  (ex_expect)
  );

  ddr_app_result u_result (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .reset_i          (reset_i),
    .ex_valid_i       (ex_valid),
    .ex_cmd_i         (ex_cmd),
    .ex_rdata_i       (ex_rdata),
    .ex_expect_i      (ex_expect),
    .row_miss_i       (row_miss),
    .rd_valid_o       (rd_valid_o),
    .rd_data_o        (rd_data_o),
    .compare_error_o  (compare_error_o),
    .mismatch_count_o (mismatch_count_o),
    .wr_count_o       (wr_count_o),
    .rd_count_o       (rd_count_o),
    .row_miss_count_o (row_miss_count_o)
  );

endmodule

`default_nettype wire

// File: vlog.f
verilog/ddr_app_pkg.sv
verilog/ddr_app_decode.sv
verilog/ddr_app_execute.sv
verilog/ddr_app_result.sv
verilog/ddr_app_top.sv
tb/tb_clk_gen.sv
tb/tb_ddr_app_checker.sv
tb/tb_ddr_app_top.sv
